// File: common/gemm_pkg.sv
// shared definitions for the matrix-multiply accelerator
// AXI field encodings and the read transaction IDs of the two operand matrices

`default_nettype none

package gemm_pkg;

    // bus geometry
    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;

    // AXI burst type and beat size codes
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_4B    = 3'b010;

    // write response code
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    // one read ID per operand matrix
    localparam logic [AXI_ID_W-1:0] ID_MAT_A = 4'd0;
    localparam logic [AXI_ID_W-1:0] ID_MAT_B = 4'd1;

endpackage

`default_nettype wire

// File: verilog/buf_sram.sv
// operand row buffer
// one write port and one read port, read data registered

`timescale 1ns/100ps
`default_nettype none

module buf_sram #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 2
) (
    input  wire                      clk,
    input  wire                      wren_i,
    input  wire [BUF_AW-1:0]         waddr_i,
    input  wire [SA_WIDTH*DW-1:0]    wdata_i,
    input  wire [BUF_AW-1:0]         raddr_i,
    output logic [SA_WIDTH*DW-1:0]   rdata_o
);

    localparam int ROW_W = SA_WIDTH * DW;

    logic [ROW_W-1:0] mem_q [2**BUF_AW];

    // same-address read during write returns the old row
    always_ff @(posedge clk) begin
        if (wren_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rdata_o <= mem_q[raddr_i];
    end

endmodule

`default_nettype wire

// File: dma/dma_beat_packer.sv
// read beat packer
// collects the R beats of one transaction ID into buffer rows and writes
// each row once its last beat has arrived

`timescale 1ns/100ps
`default_nettype none

module dma_beat_packer #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 2,
    parameter logic [gemm_pkg::AXI_ID_W-1:0] ID = gemm_pkg::ID_MAT_A
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start_i,
    input  wire                           rvalid_i,
    input  wire                           rready_i,
    input  wire [gemm_pkg::AXI_ID_W-1:0]  rid_i,
    input  wire [DW-1:0]                  rdata_i,
    input  wire                           rlast_i,
    output logic                          wren_o,
    output logic [BUF_AW-1:0]             waddr_o,
    output logic [SA_WIDTH*DW-1:0]        wdata_o,
    output logic                          last_seen_o
);

    localparam int ROW_W = SA_WIDTH * DW;
    localparam int CNT_W = $clog2(SA_WIDTH);

    logic             beat_ok;
    logic             row_done;
    logic [CNT_W-1:0] beat_cnt_q;
    logic [ROW_W-1:0] row_q;

    // accepted beat that belongs to this matrix
    assign beat_ok  = rvalid_i && rready_i && (rid_i == ID);
    assign row_done = beat_ok && (beat_cnt_q == CNT_W'(SA_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt_q  <= '0;
            wren_o      <= 1'b0;
            waddr_o     <= '0;
            last_seen_o <= 1'b0;
        end else begin
            wren_o <= row_done;
            if (beat_ok) begin
                beat_cnt_q <= row_done ? '0 : beat_cnt_q + 1'b1;
            end
            if (start_i) begin
                waddr_o <= '0;
            end else if (wren_o) begin
                waddr_o <= waddr_o + 1'b1;
            end
            if (start_i) begin
                last_seen_o <= 1'b0;
            end else if (beat_ok && rlast_i) begin
                last_seen_o <= 1'b1;
            end
        end
    end

    // first beat of a row lands in element 0
    always_ff @(posedge clk) begin
        if (beat_ok) begin
            row_q <= {rdata_i, row_q[ROW_W-1:DW]};
        end
    end

    assign wdata_o = row_q;

    a_no_beat_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        last_seen_o && !start_i |-> !beat_ok);

endmodule

`default_nettype wire

// File: dma/dma_engine.sv
// DMA engine of the matrix-multiply accelerator
// reads A and B over AXI with both bursts in flight, starts the multiply
// engine, then writes C back with a single write burst

`timescale 1ns/100ps
`default_nettype none

module dma_engine #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4
) (
    input  wire                             clk,
    input  wire                             rst_n,
    // configuration
    input  wire [gemm_pkg::AXI_ADDR_W-1:0]  mat_a_addr_i,
    input  wire [gemm_pkg::AXI_ADDR_W-1:0]  mat_b_addr_i,
    input  wire [gemm_pkg::AXI_ADDR_W-1:0]  mat_c_addr_i,
    input  wire                             start_i,
    output logic                            done_o,
    // AR channel
    output logic                            arvalid_o,
    input  wire                             arready_i,
    output logic [gemm_pkg::AXI_ID_W-1:0]   arid_o,
    output logic [gemm_pkg::AXI_ADDR_W-1:0] araddr_o,
    output logic [7:0]                      arlen_o,
    output logic [2:0]                      arsize_o,
    output logic [1:0]                      arburst_o,
    // R channel handshake
    input  wire                             rvalid_i,
    output logic                            rready_o,
    // AW channel
    output logic                            awvalid_o,
    input  wire                             awready_i,
    output logic [gemm_pkg::AXI_ID_W-1:0]   awid_o,
    output logic [gemm_pkg::AXI_ADDR_W-1:0] awaddr_o,
    output logic [7:0]                      awlen_o,
    output logic [2:0]                      awsize_o,
    output logic [1:0]                      awburst_o,
    // W channel
    output logic                            wvalid_o,
    input  wire                             wready_i,
    output logic [DW-1:0]                   wdata_o,
    output logic [DW/8-1:0]                 wstrb_o,
    output logic                            wlast_o,
    // B channel
    input  wire                             bvalid_i,
    output logic                            bready_o,
    input  wire [1:0]                       bresp_i,
    // packers and multiply engine
    input  wire                             rlast_seen_a_i,
    input  wire                             rlast_seen_b_i,
    output logic                            mm_start_o,
    input  wire                             mm_done_i,
    input  wire [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0] accum_i
);

    localparam int ACC_W  = 2 * DW + 1;
    localparam int NUM_EL = SA_WIDTH * SA_WIDTH;
    localparam int BEAT_W = $clog2(NUM_EL);
    localparam logic [7:0] BURST_LEN = 8'(NUM_EL - 1);

    typedef enum logic [3:0] {
        S_IDLE, S_ADDR_A, S_ADDR_B, S_LOAD, S_START,
        S_WAIT_MM, S_ADDR_C, S_WRITE_C, S_RESP
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic [BEAT_W-1:0] beat_q;
    logic              w_fire;
    logic              last_beat;

    assign w_fire    = wvalid_o && wready_i;
    assign last_beat = (beat_q == BEAT_W'(NUM_EL - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (start_i) state_d = S_ADDR_A;
            S_ADDR_A:  if (arready_i) state_d = S_ADDR_B;
            S_ADDR_B:  if (arready_i) state_d = S_LOAD;
            // both bursts fully received and the last rows written
            S_LOAD:    if (rlast_seen_a_i && rlast_seen_b_i) state_d = S_START;
            S_START:   state_d = S_WAIT_MM;
            S_WAIT_MM: if (mm_done_i) state_d = S_ADDR_C;
            S_ADDR_C:  if (awready_i) state_d = S_WRITE_C;
            S_WRITE_C: if (w_fire && last_beat) state_d = S_RESP;
            S_RESP:    if (bvalid_i) state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            beat_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == S_RESP) && bvalid_i;
            if (state_q == S_ADDR_C) begin
                beat_q <= '0;
            end else if (w_fire) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // read requests, A first then B
    assign arvalid_o = (state_q == S_ADDR_A) || (state_q == S_ADDR_B);
    assign arid_o    = (state_q == S_ADDR_B) ? gemm_pkg::ID_MAT_B : gemm_pkg::ID_MAT_A;
    assign araddr_o  = (state_q == S_ADDR_B) ? mat_b_addr_i : mat_a_addr_i;
    assign arlen_o   = BURST_LEN;
    assign arsize_o  = gemm_pkg::AXI_SIZE_4B;
    assign arburst_o = gemm_pkg::AXI_BURST_INCR;

    // A beats may already return while B is being requested
    assign rready_o = ((state_q == S_ADDR_B) || (state_q == S_LOAD))
                      && !(rlast_seen_a_i && rlast_seen_b_i);

    assign mm_start_o = (state_q == S_START);

    // single write stream, ID 0
    assign awvalid_o = (state_q == S_ADDR_C);
    assign awid_o    = '0;
    assign awaddr_o  = mat_c_addr_i;
    assign awlen_o   = BURST_LEN;
    assign awsize_o  = gemm_pkg::AXI_SIZE_4B;
    assign awburst_o = gemm_pkg::AXI_BURST_INCR;

    // C in row-major order, low DW bits of each accumulator
    assign wvalid_o = (state_q == S_WRITE_C);
    assign wdata_o  = accum_i[beat_q*ACC_W +: DW];
    assign wstrb_o  = '1;
    assign wlast_o  = wvalid_o && last_beat;

    assign bready_o = (state_q == S_RESP);

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(arid_o));

    a_bresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i |-> bresp_i == gemm_pkg::AXI_RESP_OKAY);

    a_mm_done_wait: assert property (@(posedge clk) disable iff (!rst_n)
        mm_done_i |-> state_q == S_WAIT_MM);

    // read data only while a read burst is outstanding
    a_r_window: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i |-> (state_q == S_ADDR_B) || (state_q == S_LOAD));

endmodule

`default_nettype wire

// File: mm/mm_engine.sv
// multiply engine
// sequential outer-product MAC array, one buffer row pair per cycle,
// signed accumulators of 2*DW+1 bits

`timescale 1ns/100ps
`default_nettype none

module mm_engine #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 2
) (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire                                    start_i,
    output logic                                   done_o,
    output logic [BUF_AW-1:0]                      buf_a_raddr_o,
    input  wire [SA_WIDTH*DW-1:0]                  buf_a_rdata_i,
    output logic [BUF_AW-1:0]                      buf_b_raddr_o,
    input  wire [SA_WIDTH*DW-1:0]                  buf_b_rdata_i,
    output logic [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0]  accum_o
);

    localparam int ACC_W = 2 * DW + 1;

    logic                    rd_active_q;
    logic [BUF_AW-1:0]       rd_k_q;
    logic                    mac_valid_q;
    logic                    mac_last_q;
    logic signed [ACC_W-1:0] acc_q [SA_WIDTH][SA_WIDTH];
    logic signed [2*DW-1:0]  prod [SA_WIDTH][SA_WIDTH];

    // row k of A is column k, row k of B is row k
    for (genvar gi = 0; gi < SA_WIDTH; gi++) begin : g_row
        for (genvar gj = 0; gj < SA_WIDTH; gj++) begin : g_col
            assign prod[gi][gj] = $signed(buf_a_rdata_i[gi*DW +: DW])
                                * $signed(buf_b_rdata_i[gj*DW +: DW]);
            assign accum_o[(gi*SA_WIDTH+gj)*ACC_W +: ACC_W] = acc_q[gi][gj];
        end
    end

    // read rows 0..SA_WIDTH-1, MAC follows one cycle behind
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active_q <= 1'b0;
            rd_k_q      <= '0;
            mac_valid_q <= 1'b0;
            mac_last_q  <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            mac_valid_q <= rd_active_q;
            mac_last_q  <= rd_active_q && (rd_k_q == BUF_AW'(SA_WIDTH - 1));
            done_o      <= mac_last_q;
            if (start_i) begin
                rd_active_q <= 1'b1;
                rd_k_q      <= '0;
            end else if (rd_active_q) begin
                if (rd_k_q == BUF_AW'(SA_WIDTH - 1)) begin
                    rd_active_q <= 1'b0;
                end
                rd_k_q <= rd_k_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                if (start_i) begin
                    acc_q[i][j] <= '0;
                end else if (mac_valid_q) begin
                    acc_q[i][j] <= acc_q[i][j] + prod[i][j];
                end
            end
        end
    end

    assign buf_a_raddr_o = rd_k_q;
    assign buf_b_raddr_o = rd_k_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !(rd_active_q || mac_valid_q));

endmodule

`default_nettype wire

// File: verilog/gemm_top.sv
// matrix-multiply accelerator top level
// DMA engine, one beat packer and row buffer per operand, multiply engine

`timescale 1ns/100ps
`default_nettype none

module gemm_top #(
    parameter int DW       = 32,
    parameter int SA_WIDTH = 4,
    parameter int BUF_AW   = 2
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [gemm_pkg::AXI_ADDR_W-1:0]  mat_a_addr_i,
    input  wire [gemm_pkg::AXI_ADDR_W-1:0]  mat_b_addr_i,
    input  wire [gemm_pkg::AXI_ADDR_W-1:0]  mat_c_addr_i,
    input  wire                             start_i,
    output wire                             done_o,
    // AR channel
    output wire                             arvalid_o,
    input  wire                             arready_i,
    output wire [gemm_pkg::AXI_ID_W-1:0]    arid_o,
    output wire [gemm_pkg::AXI_ADDR_W-1:0]  araddr_o,
    output wire [7:0]                       arlen_o,
    output wire [2:0]                       arsize_o,
    output wire [1:0]                       arburst_o,
    // R channel
    input  wire                             rvalid_i,
    output wire                             rready_o,
    input  wire [gemm_pkg::AXI_ID_W-1:0]    rid_i,
    input  wire [DW-1:0]                    rdata_i,
    input  wire                             rlast_i,
    // AW channel
    output wire                             awvalid_o,
    input  wire                             awready_i,
    output wire [gemm_pkg::AXI_ID_W-1:0]    awid_o,
    output wire [gemm_pkg::AXI_ADDR_W-1:0]  awaddr_o,
    output wire [7:0]                       awlen_o,
    output wire [2:0]                       awsize_o,
    output wire [1:0]                       awburst_o,
    // W channel
    output wire                             wvalid_o,
    input  wire                             wready_i,
    output wire [DW-1:0]                    wdata_o,
    output wire [DW/8-1:0]                  wstrb_o,
    output wire                             wlast_o,
    // B channel
    input  wire                             bvalid_i,
    output wire                             bready_o,
    input  wire [1:0]                       bresp_i
);

    localparam int ROW_W = SA_WIDTH * DW;

    wire                 seen_a;
    wire                 seen_b;
    wire                 a_wren;
    wire [BUF_AW-1:0]    a_waddr;
    wire [ROW_W-1:0]     a_wdata;
    wire [BUF_AW-1:0]    a_raddr;
    wire [ROW_W-1:0]     a_rdata;
    wire                 b_wren;
    wire [BUF_AW-1:0]    b_waddr;
    wire [ROW_W-1:0]     b_wdata;
    wire [BUF_AW-1:0]    b_raddr;
    wire [ROW_W-1:0]     b_rdata;
    wire                 mm_start;
    wire                 mm_done;
    wire [SA_WIDTH*SA_WIDTH*(2*DW+1)-1:0] accum;

    dma_engine #(.DW(DW), .SA_WIDTH(SA_WIDTH)) u_dma (
        .clk, .rst_n, .mat_a_addr_i, .mat_b_addr_i, .mat_c_addr_i, .start_i, .done_o,
        .arvalid_o, .arready_i, .arid_o, .araddr_o, .arlen_o, .arsize_o, .arburst_o,
        .rvalid_i, .rready_o,
        .awvalid_o, .awready_i, .awid_o, .awaddr_o, .awlen_o, .awsize_o, .awburst_o,
        .wvalid_o, .wready_i, .wdata_o, .wstrb_o, .wlast_o,
        .bvalid_i, .bready_o, .bresp_i,
        .rlast_seen_a_i(seen_a), .rlast_seen_b_i(seen_b),
        .mm_start_o(mm_start), .mm_done_i(mm_done), .accum_i(accum)
    );

    // packer flags are cleared when the multiply starts
    dma_beat_packer #(
        .DW(DW), .SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW), .ID(gemm_pkg::ID_MAT_A)
    ) u_pack_a (
        .clk, .rst_n, .start_i(mm_start),
        .rvalid_i, .rready_i(rready_o), .rid_i, .rdata_i, .rlast_i,
        .wren_o(a_wren), .waddr_o(a_waddr), .wdata_o(a_wdata), .last_seen_o(seen_a)
    );

    dma_beat_packer #(
        .DW(DW), .SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW), .ID(gemm_pkg::ID_MAT_B)
    ) u_pack_b (
        .clk, .rst_n, .start_i(mm_start),
        .rvalid_i, .rready_i(rready_o), .rid_i, .rdata_i, .rlast_i,
        .wren_o(b_wren), .waddr_o(b_waddr), .wdata_o(b_wdata), .last_seen_o(seen_b)
    );

    buf_sram #(.DW(DW), .SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW)) u_buf_a (
        .clk, .wren_i(a_wren), .waddr_i(a_waddr), .wdata_i(a_wdata),
        .raddr_i(a_raddr), .rdata_o(a_rdata)
    );

    buf_sram #(.DW(DW), .SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW)) u_buf_b (
        .clk, .wren_i(b_wren), .waddr_i(b_waddr), .wdata_i(b_wdata),
        .raddr_i(b_raddr), .rdata_o(b_rdata)
    );

    mm_engine #(.DW(DW), .SA_WIDTH(SA_WIDTH), .BUF_AW(BUF_AW)) u_mm (
        .clk, .rst_n, .start_i(mm_start), .done_o(mm_done),
        .buf_a_raddr_o(a_raddr), .buf_a_rdata_i(a_rdata),
        .buf_b_raddr_o(b_raddr), .buf_b_rdata_i(b_rdata),
        .accum_o(accum)
    );

endmodule

`default_nettype wire

// File: verif/axi_mem_model.sv
// AXI slave memory for the accelerator testbench
// random ready/valid stalls, A and B read beats interleaved at random

`timescale 1ns/100ps
`default_nettype none

module axi_mem_model #(
    parameter int SEED = 32'h9b4c
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         arvalid_i,
    output logic        arready_o,
    input  wire [3:0]   arid_i,
    input  wire [31:0]  araddr_i,
    input  wire [7:0]   arlen_i,
    output logic        rvalid_o,
    input  wire         rready_i,
    output logic [3:0]  rid_o,
    output logic [31:0] rdata_o,
    output logic        rlast_o,
    input  wire         awvalid_i,
    output logic        awready_o,
    input  wire [31:0]  awaddr_i,
    input  wire         wvalid_i,
    output logic        wready_o,
    input  wire [31:0]  wdata_i,
    input  wire         wlast_i,
    output logic        bvalid_o,
    input  wire         bready_i,
    output logic [1:0]  bresp_o
);

    logic [31:0] mem [256];
    logic [31:0] burst_addr [2];
    int          burst_left [2];
    int          burst_beat [2];
    int          cur_id;
    int          pick;
    int          w_base;
    int          w_count;
    logic        b_pend;
    logic        ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic        rst_q;
    logic        ar_sel;
    logic [31:0] ar_addr;
    logic [7:0]  ar_len;
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic        w_last;
    integer      mseed;

    // all channels idle
    task automatic clear_outputs();
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rid_o     = 4'd0;
        rdata_o   = 32'd0;
        rlast_o   = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        bresp_o   = 2'b00;
    endtask

    initial begin
        mseed = SEED + 7;
        rst_q = 1'b0;
        clear_outputs();
    end

    // handshakes and request fields are taken at the rising edge
    always @(posedge clk) begin
        rst_q   = rst_n;
        ar_fire = arvalid_i && arready_o;
        r_fire  = rvalid_o && rready_i;
        aw_fire = awvalid_i && awready_o;
        w_fire  = wvalid_i && wready_o;
        b_fire  = bvalid_o && bready_i;
        ar_sel  = arid_i[0];
        ar_addr = araddr_i;
        ar_len  = arlen_i;
        aw_addr = awaddr_i;
        w_data  = wdata_i;
        w_last  = wlast_i;
    end

    // outputs change on the falling edge
    always @(negedge clk) begin
        if (!rst_q) begin
            clear_outputs();
            burst_left[0] = 0;
            burst_left[1] = 0;
            b_pend = 0;
            w_count = 0;
            w_base = 0;
        end else begin
            if (ar_fire) begin
                burst_addr[ar_sel] = ar_addr;
                burst_left[ar_sel] = int'(ar_len) + 1;
                burst_beat[ar_sel] = 0;
            end
            if (r_fire) begin
                burst_left[cur_id]--;
                burst_beat[cur_id]++;
                rvalid_o = 0;
            end
            if (!rvalid_o && (($random(mseed) & 3) != 0)) begin
                if (burst_left[0] > 0 && burst_left[1] > 0) begin
                    pick = $random(mseed) & 1;
                end else if (burst_left[0] > 0) begin
                    pick = 0;
                end else if (burst_left[1] > 0) begin
                    pick = 1;
                end else begin
                    pick = -1;
                end
                if (pick >= 0) begin
                    cur_id   = pick;
                    rvalid_o = 1;
                    rid_o    = 4'(pick);
                    rdata_o  = mem[int'(burst_addr[pick][9:2]) + burst_beat[pick]];
                    rlast_o  = (burst_left[pick] == 1);
                end
            end
            if (aw_fire) begin
                w_base  = int'(aw_addr[9:2]);
                w_count = 0;
            end
            if (w_fire) begin
                mem[(w_base + w_count) % 256] = w_data;
                w_count++;
                if (w_last) begin
                    b_pend = 1;
                end
            end
            if (b_fire) begin
                bvalid_o = 0;
            end
            if (b_pend && !bvalid_o && (($random(mseed) & 1) != 0)) begin
                bvalid_o = 1;
                bresp_o  = 2'b00;
                b_pend   = 0;
            end
            arready_o = (($random(mseed) & 3) != 0);
            awready_o = (($random(mseed) & 3) != 0);
            wready_o  = (($random(mseed) & 3) != 0);
        end
    end

endmodule

`default_nettype wire

// File: verif/gemm_checker.sv
// bus checker for the accelerator
// compares read and write requests, every W beat and each done pulse

`timescale 1ns/100ps
`default_nettype none

module gemm_checker (
    input wire        clk,
    input wire        rst_n,
    input wire        start_i,
    input wire        done_i,
    input wire        arvalid_i,
    input wire        arready_i,
    input wire [3:0]  arid_i,
    input wire [31:0] araddr_i,
    input wire [7:0]  arlen_i,
    input wire [2:0]  arsize_i,
    input wire [1:0]  arburst_i,
    input wire        awvalid_i,
    input wire        awready_i,
    input wire [3:0]  awid_i,
    input wire [31:0] awaddr_i,
    input wire [7:0]  awlen_i,
    input wire [2:0]  awsize_i,
    input wire [1:0]  awburst_i,
    input wire        wvalid_i,
    input wire        wready_i,
    input wire [31:0] wdata_i,
    input wire [3:0]  wstrb_i,
    input wire        wlast_i,
    input wire        bvalid_i,
    input wire        bready_i
);

    // written by the testbench before each run
    logic [31:0] exp_c [16];
    logic [31:0] exp_a_addr;
    logic [31:0] exp_b_addr;
    logic [31:0] exp_c_addr;

    int          err_count = 0;
    int          done_count = 0;
    int          beat = 0;
    int          reads = 0;
    logic        b_seen = 0;
    logic        started = 0;
    logic [3:0]  want_id;
    logic [31:0] want_addr;

    // request payloads held while valid waits for ready
    wire  [48:0] ar_pay = {arid_i, araddr_i, arlen_i, arsize_i, arburst_i};
    wire  [48:0] aw_pay = {awid_i, awaddr_i, awlen_i, awsize_i, awburst_i};
    wire  [36:0] w_pay  = {wdata_i, wstrb_i, wlast_i};
    logic        ar_hold = 0;
    logic        aw_hold = 0;
    logic        w_hold = 0;
    logic [48:0] ar_prev;
    logic [48:0] aw_prev;
    logic [36:0] w_prev;

    always @(posedge clk) begin
        if (rst_n) begin
            if (start_i) begin
                started = 1;
            end
            if (!started && (done_i || arvalid_i || awvalid_i || wvalid_i)) begin
                $display("ERROR: bus activity or done before the first start at %0t", $time);
                err_count++;
            end
            if ((ar_hold && (!arvalid_i || ar_pay != ar_prev))
                || (aw_hold && (!awvalid_i || aw_pay != aw_prev))
                || (w_hold && (!wvalid_i || w_pay != w_prev))) begin
                $display("ERROR: request changed while waiting for ready at %0t", $time);
                err_count++;
            end
            ar_hold = arvalid_i && !arready_i;
            aw_hold = awvalid_i && !awready_i;
            w_hold  = wvalid_i && !wready_i;
            ar_prev = ar_pay;
            aw_prev = aw_pay;
            w_prev  = w_pay;
            // A is requested first, then B
            if (arvalid_i && arready_i) begin
                want_id   = (reads == 0) ? gemm_pkg::ID_MAT_A : gemm_pkg::ID_MAT_B;
                want_addr = (reads == 0) ? exp_a_addr : exp_b_addr;
                if (reads > 1) begin
                    $display("ERROR: more than two read requests in one run at %0t", $time);
                    err_count++;
                end else if (arid_i != want_id || araddr_i != want_addr || arlen_i != 8'd15
                             || arsize_i != 3'b010 || arburst_i != 2'b01) begin
                    $display("MISMATCH %0t: read id %0d addr %h len %0d size %0d burst %0d",
                             $time, arid_i, araddr_i, arlen_i, arsize_i, arburst_i);
                    $display("  expected id %0d addr %h len 15 size 2 burst 1",
                             want_id, want_addr);
                    err_count++;
                end
                reads++;
            end
            if (awvalid_i && awready_i && (awaddr_i != exp_c_addr || awlen_i != 8'd15
                                           || awsize_i != 3'b010 || awburst_i != 2'b01)) begin
                $display("MISMATCH %0t: write address %h len %0d size %0d burst %0d",
                         $time, awaddr_i, awlen_i, awsize_i, awburst_i);
                $display("  expected %h len 15 size 2 burst 1", exp_c_addr);
                err_count++;
            end
            if (wvalid_i && wready_i) begin
                if (beat > 15) begin
                    $display("ERROR: more than 16 write beats at %0t", $time);
                    err_count++;
                end else if (wdata_i != exp_c[beat] || wstrb_i != 4'hf
                             || wlast_i != (beat == 15)) begin
                    $display("MISMATCH %0t: beat %0d data %h strb %h last %b, expected %h",
                             $time, beat, wdata_i, wstrb_i, wlast_i, exp_c[beat]);
                    err_count++;
                end
                beat++;
            end
            if (bvalid_i && bready_i) begin
                b_seen = 1;
            end
            if (done_i) begin
                if (beat != 16 || !b_seen || reads != 2) begin
                    $display("ERROR: done at %0t after %0d reads, %0d beats, response %b",
                             $time, reads, beat, b_seen);
                    err_count++;
                end
                done_count++;
                beat = 0;
                reads = 0;
                b_seen = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_gemm.sv
// testbench for the matrix-multiply accelerator
// three runs on random signed data, one with a start pulse while busy

`timescale 1ns/100ps
`default_nettype none

module tb_gemm #(
    parameter int SEED = 32'h9b4c
);

    logic        clk = 0;
    logic        rst_n;
    logic        start;
    logic [31:0] a_addr, b_addr, c_addr;
    integer      seed;
    int          tb_errors = 0;

    wire        done, arvalid, arready, rvalid, rready, rlast;
    wire        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    wire [3:0]  arid, rid, awid, wstrb;
    wire [31:0] araddr, awaddr, rdata, wdata;
    wire [7:0]  arlen, awlen;
    wire [2:0]  arsize, awsize;
    wire [1:0]  arburst, awburst, bresp;

    always #4 clk = ~clk;

    gemm_top #(.DW(32), .SA_WIDTH(4), .BUF_AW(2)) u_dut (
        .clk, .rst_n, .mat_a_addr_i(a_addr), .mat_b_addr_i(b_addr), .mat_c_addr_i(c_addr),
        .start_i(start), .done_o(done),
        .arvalid_o(arvalid), .arready_i(arready), .arid_o(arid), .araddr_o(araddr),
        .arlen_o(arlen), .arsize_o(arsize), .arburst_o(arburst),
        .rvalid_i(rvalid), .rready_o(rready), .rid_i(rid), .rdata_i(rdata), .rlast_i(rlast),
        .awvalid_o(awvalid), .awready_i(awready), .awid_o(awid), .awaddr_o(awaddr),
        .awlen_o(awlen), .awsize_o(awsize), .awburst_o(awburst),
        .wvalid_o(wvalid), .wready_i(wready), .wdata_o(wdata), .wstrb_o(wstrb),
        .wlast_o(wlast), .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp)
    );

    axi_mem_model #(.SEED(SEED)) u_mem (
        .clk, .rst_n, .arvalid_i(arvalid), .arready_o(arready), .arid_i(arid),
        .araddr_i(araddr), .arlen_i(arlen), .rvalid_o(rvalid), .rready_i(rready),
        .rid_o(rid), .rdata_o(rdata), .rlast_o(rlast), .awvalid_i(awvalid),
        .awready_o(awready), .awaddr_i(awaddr), .wvalid_i(wvalid), .wready_o(wready),
        .wdata_i(wdata), .wlast_i(wlast), .bvalid_o(bvalid), .bready_i(bready),
        .bresp_o(bresp)
    );

    gemm_checker u_chk (
        .clk, .rst_n, .start_i(start), .done_i(done),
        .arvalid_i(arvalid), .arready_i(arready), .arid_i(arid), .araddr_i(araddr),
        .arlen_i(arlen), .arsize_i(arsize), .arburst_i(arburst),
        .awvalid_i(awvalid), .awready_i(awready), .awid_i(awid), .awaddr_i(awaddr),
        .awlen_i(awlen), .awsize_i(awsize), .awburst_i(awburst),
        .wvalid_i(wvalid), .wready_i(wready), .wdata_i(wdata), .wstrb_i(wstrb),
        .wlast_i(wlast), .bvalid_i(bvalid), .bready_i(bready)
    );

    // C[i][j] from the image, A column-major and B row-major
    function automatic logic [31:0] ref_elem(logic [31:0] a, logic [31:0] b, int i, int j);
        logic signed [63:0] sum;
        int                 k;
        sum = 0;
        for (k = 0; k < 4; k++) begin
            sum += $signed(u_mem.mem[int'(a[9:2]) + k*4 + i])
                 * $signed(u_mem.mem[int'(b[9:2]) + k*4 + j]);
        end
        return sum[31:0];
    endfunction

    task automatic run_once(input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] c, input bit poke_busy);
        int   cyc;
        logic got;
        u_chk.exp_a_addr = a;
        u_chk.exp_b_addr = b;
        u_chk.exp_c_addr = c;
        for (int e = 0; e < 16; e++) begin
            u_chk.exp_c[e] = ref_elem(a, b, e / 4, e % 4);
        end
        @(negedge clk);
        a_addr = a;
        b_addr = b;
        c_addr = c;
        start  = 1;
        @(negedge clk);
        start = 0;
        if (poke_busy) begin
            repeat (4) @(negedge clk);
            start = 1;
            @(negedge clk);
            start = 0;
        end
        got = 0;
        for (cyc = 0; cyc < 3000 && !got; cyc++) begin
            @(negedge clk);
            got = done;
        end
        if (!got) begin
            $display("ERROR: timed out waiting for done at %0t", $time);
            tb_errors++;
        end
        repeat (5) @(negedge clk);
    endtask

    initial begin
        seed  = SEED;
        rst_n = 0;
        start = 0;
        a_addr = 0;
        b_addr = 0;
        c_addr = 0;
        for (int w = 0; w < 256; w++) begin
            u_mem.mem[w] = $random(seed);
        end
        repeat (8) @(negedge clk);
        rst_n = 1;
        repeat (10) @(negedge clk);
        run_once(32'h000, 32'h100, 32'h200, 1'b0);
        run_once(32'h140, 32'h040, 32'h300, 1'b1);
        run_once(32'h080, 32'h2c0, 32'h380, 1'b0);
        repeat (20) @(negedge clk);
        if (u_chk.done_count != 3) begin
            $display("ERROR: %0d done pulses for 3 runs", u_chk.done_count);
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d", u_chk.err_count, tb_errors);
        if (u_chk.err_count == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
common/gemm_pkg.sv
verilog/buf_sram.sv
dma/dma_beat_packer.sv
dma/dma_engine.sv
mm/mm_engine.sv
verilog/gemm_top.sv
verif/axi_mem_model.sv
verif/gemm_checker.sv
verif/tb_gemm.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gemm
SEED      ?= 39756
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sources.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --assert --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD) -f $(FLIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
